// File: hw/lane_mem_pkg.sv
/*
 Shared definitions for the byte-lane load/store memory.
 Sizes, access size codes, the request and per-lane command
 records, the load control record kept for the response, and
 the union used to view the four lane bytes as a word.
 Modules take these with a wildcard import in their header.
*/

package lane_mem_pkg;

   // ========================================
   // Sizes
   // ========================================

   localparam int data_width      = 32;
   localparam int lane_count      = 4;
   localparam int lane_width      = 8;
   // Words held by each bank
   localparam int word_count      = 256;
   localparam int word_addr_width = 8;
   // Request byte address
   localparam int byte_addr_width = 10;

   // Access size in the same encoding as a bus size field
   typedef logic [1:0] size_t;

   localparam size_t size_byte = 2'd0;
   localparam size_t size_half = 2'd1;
   localparam size_t size_word = 2'd2;

   // ========================================
   // Records
   // ========================================

   typedef struct packed {
      logic [byte_addr_width-1:0] addr;
      size_t                      size;
      logic                       write;
      logic                       unsigned_ld;
      logic [data_width-1:0]      wdata;
   } lsu_req_t;

   // What a single bank sees in one cycle
   typedef struct packed {
      logic                       wr;
      logic                       rd;
      logic [word_addr_width-1:0] idx;
      logic [lane_width-1:0]      data;
   } lane_cmd_t;

   // Kept from load acceptance until the response is formed
   typedef struct packed {
      size_t      size;
      logic       unsigned_ld;
      logic [1:0] offset;
   } ld_ctl_t;

   // Read word seen per byte or per halfword
   typedef union packed {
      logic [lane_count-1:0][lane_width-1:0] bytes;
      logic [1:0][2*lane_width-1:0]          halves;
   } lane_word_u;

endpackage

// File: hw/store_aligner.sv
/*
 Request side of the byte-lane memory, purely combinational.
 An accepted store is split into per-lane write enables with
 its data shifted onto the covered lanes. An accepted load
 reads all four lanes and hands its size, sign mode and
 offset to the load extractor.
*/

`timescale 1ns/1ps

module store_aligner
   import lane_mem_pkg::*;
(
   input  logic                             req_valid,
   input  lsu_req_t                         req,
   input  logic                             req_ready,
   output lane_cmd_t [lane_count-1:0]       lane_cmd,
   output logic                             load_start,
   output ld_ctl_t                          ld_ctl
);

   logic                                  accept;
   logic [1:0]                            offset;
   logic [lane_count-1:0]                 byte_en;
   logic [lane_count-1:0][lane_width-1:0] wr_lanes;

   assign accept     = req_valid & req_ready;
   assign offset     = req.addr[1:0];
   assign load_start = accept & ~req.write;

   assign ld_ctl.size        = req.size;
   assign ld_ctl.unsigned_ld = req.unsigned_ld;
   assign ld_ctl.offset      = offset;

   // Lane enables and shifted store data
   always_comb begin
      case (req.size)
         size_byte: begin
            byte_en  = 4'b0001 << offset;
            wr_lanes = {24'b0, req.wdata[7:0]} << {offset, 3'b000};
         end
         size_half: begin
            // Only address bit 1 matters for a halfword
            byte_en  = offset[1] ? 4'b1100 : 4'b0011;
            wr_lanes = {16'b0, req.wdata[15:0]} << {offset[1], 4'b0000};
         end
         default: begin
            byte_en  = 4'b1111;
            wr_lanes = req.wdata;
         end
      endcase
   end

   always_comb begin
      for (int i = 0; i < lane_count; i++) begin
         lane_cmd[i].wr   = accept & req.write & byte_en[i];
         lane_cmd[i].rd   = load_start;
         lane_cmd[i].idx  = req.addr[byte_addr_width-1:2];
         lane_cmd[i].data = wr_lanes[i];
      end
   end

endmodule

// File: hw/byte_bank.sv
/*
 One byte-wide storage bank, one per lane.
 Writes land on the clock edge. A read registers the addressed
 byte into rdata, which then holds until the next read.
*/

`timescale 1ns/1ps

module byte_bank
   import lane_mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  lane_cmd_t             cmd,
   output logic [lane_width-1:0] rdata
);

   logic [lane_width-1:0] mem [word_count];

   // Storage array
   always_ff @(posedge clk) begin
      if (cmd.wr) begin
         mem[cmd.idx] <= cmd.data;
      end
   end

   // Read register that holds between reads
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (cmd.rd) begin
         rdata <= mem[cmd.idx];
      end
   end

endmodule

// File: hw/load_extractor.sv
/*
 Response side of the byte-lane memory.
 Keeps the control of the load in flight and the response
 valid flag, and forms rsp_data from the registered lane bytes.
 A byte or halfword is picked from the word by the offset, then
 zero or sign extended. Also drives req_ready so a new request
 is taken only when the response slot is free.
*/

`timescale 1ns/1ps

module load_extractor
   import lane_mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  load_start,
   input  ld_ctl_t               ld_ctl,
   input  lane_word_u            lanes,
   input  logic                  rsp_ready,
   output logic                  req_ready,
   output logic                  rsp_valid,
   output logic [data_width-1:0] rsp_data
);

   ld_ctl_t                 ctl_q;
   logic [lane_width-1:0]   sel_byte;
   logic [2*lane_width-1:0] sel_half;

   // Slot is free, or the held response leaves this cycle
   assign req_ready = ~rsp_valid | rsp_ready;

   // ========================================
   // Response state
   // ========================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
         ctl_q     <= '0;
      end else begin
         if (load_start) begin
            rsp_valid <= 1'b1;
            ctl_q     <= ld_ctl;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // ========================================
   // Extraction
   // ========================================

   assign sel_byte = lanes.bytes[ctl_q.offset];
   // Halfword ignores address bit 0
   assign sel_half = lanes.halves[ctl_q.offset[1]];

   always_comb begin
      case (ctl_q.size)
         size_byte: begin
            if (ctl_q.unsigned_ld) begin
               rsp_data = {{(data_width-lane_width){1'b0}}, sel_byte};
            end else begin
               rsp_data = {{(data_width-lane_width){sel_byte[lane_width-1]}}, sel_byte};
            end
         end
         size_half: begin
            if (ctl_q.unsigned_ld) begin
               rsp_data = {{(data_width-2*lane_width){1'b0}}, sel_half};
            end else begin
               rsp_data = {{(data_width-2*lane_width){sel_half[2*lane_width-1]}}, sel_half};
            end
         end
         // Whole word with the offset unused
         default: begin
            rsp_data = lanes.bytes;
         end
      endcase
   end

endmodule

// File: hw/byte_lane_mem.sv
/*
 Top level of the byte-lane load/store memory.
 Requests go through the store aligner to four byte banks.
 The bank read bytes form one word for the load extractor,
 which returns one response per load one cycle after it is
 accepted. Stores give no response.
*/

`timescale 1ns/1ps

module byte_lane_mem
   import lane_mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  lsu_req_t              req,
   output logic                  req_ready,
   output logic                  rsp_valid,
   output logic [data_width-1:0] rsp_data,
   input  logic                  rsp_ready
);

   lane_cmd_t [lane_count-1:0]           lane_cmd;
   logic                                 load_start;
   ld_ctl_t                              ld_ctl;
   wire [lane_count-1:0][lane_width-1:0] lane_bytes;
   lane_word_u                           lane_word;

   // ========================================
   // Request split
   // ========================================

   store_aligner u_aligner (
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .lane_cmd   (lane_cmd),
      .load_start (load_start),
      .ld_ctl     (ld_ctl)
   );

   // One bank per byte lane
   for (genvar i = 0; i < lane_count; i++) begin : g_lane
      byte_bank u_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .cmd   (lane_cmd[i]),
         .rdata (lane_bytes[i])
      );
   end

   assign lane_word.bytes = lane_bytes;

   // ========================================
   // Response
   // ========================================

   load_extractor u_extract (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_start (load_start),
      .ld_ctl     (ld_ctl),
      .lanes      (lane_word),
      .rsp_ready  (rsp_ready),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data)
   );

endmodule

// File: bench/byte_lane_mem_checker.sv
/*
 Handshake assertions for the byte-lane memory top level.
 Bound to every byte_lane_mem instance to watch its request
 and response ports.
*/

`timescale 1ns/1ps

module byte_lane_mem_checker
   import lane_mem_pkg::*;
(
   input logic                  clk,
   input logic                  rst_n,
   input logic                  req_valid,
   input lsu_req_t              req,
   input logic                  req_ready,
   input logic                  rsp_valid,
   input logic [data_width-1:0] rsp_data,
   input logic                  rsp_ready
);

   // Held response keeps its valid and data
   a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
      else $error("held response changed before it was taken");

   // Free response slot always takes requests
   a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !rsp_valid |-> req_ready)
      else $error("req_ready low with no response pending");

   a_reset_idle: assert property (@(posedge clk)
      !rst_n |-> !rsp_valid)
      else $error("rsp_valid high during reset");

   a_load_latency: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && req_ready && !req.write |=> rsp_valid)
      else $error("load not answered one cycle after acceptance");

endmodule

bind byte_lane_mem byte_lane_mem_checker u_checker (
   .clk       (clk),
   .rst_n     (rst_n),
   .req_valid (req_valid),
   .req       (req),
   .req_ready (req_ready),
   .rsp_valid (rsp_valid),
   .rsp_data  (rsp_data),
   .rsp_ready (rsp_ready)
);

// File: bench/tb_byte_lane_mem.sv
/*
 Testbench for the byte-lane load/store memory.
 Drives seeded random requests on the falling clock edge and keeps
 a byte-array model of the memory. A monitor on the rising edge
 updates the model on accepted stores, queues the expected value of
 each accepted load and checks every response transfer against it.
 One line is printed per test, then the counts and the verdict.
*/

`timescale 1ns/1ps

module tb_byte_lane_mem
   import lane_mem_pkg::*;
;

   // ========================================
   // Test sizes and run limit
   // ========================================

   localparam int reset_cycles    = 10;
   localparam int fill_reqs       = word_count;
   localparam int t1_reqs         = 2;
   localparam int t2_reqs         = 17;
   localparam int t3_words        = 8;
   localparam int t3_reqs         = t3_words * 17;
   localparam int t4_reqs         = 200;
   localparam int t5_reqs         = 2000;
   localparam int total_requests  = fill_reqs + t1_reqs + t2_reqs + t3_reqs + t4_reqs + t5_reqs;
   localparam int watchdog_cycles = reset_cycles + total_requests * 20;

   logic       clk;
   logic       rst_n;
   logic       req_valid;
   lsu_req_t   req;
   logic       req_ready;
   logic       rsp_valid;
   logic [31:0] rsp_data;
   logic       rsp_ready;

   // Reference memory with one entry per byte address
   logic [7:0]  model [1024];
   logic [31:0] exp_q [$];

   // Mode 0 keeps rsp_ready high, 1 toggles it in stretches, 2 draws it each cycle
   int ready_mode;
   int stretch_left;

   // Monitor state
   logic        load_due;
   logic        hold_due;
   logic [31:0] held_data;
   int          mon_errors;
   int          mon_checks;
   int          load_count;
   int          rsp_count;

   // Sequence state
   int seq_errors;
   int seq_checks;
   int test_count;

   byte_lane_mem u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .rsp_ready (rsp_ready)
   );

   always #5 clk = ~clk;

   // ========================================
   // Reference model
   // ========================================

   function automatic void model_store(input lsu_req_t r);
      logic [9:0] base;
      case (r.size)
         size_byte: begin
            model[r.addr] = r.wdata[7:0];
         end
         size_half: begin
            base = {r.addr[9:1], 1'b0};
            model[base]         = r.wdata[7:0];
            model[base + 10'd1] = r.wdata[15:8];
         end
         default: begin
            base = {r.addr[9:2], 2'b00};
            for (int k = 0; k < 4; k++) begin
               model[base + 10'(k)] = r.wdata[8*k +: 8];
            end
         end
      endcase
   endfunction

   function automatic logic [31:0] expected_load(input lsu_req_t r);
      logic [9:0]  base;
      logic [7:0]  b;
      logic [15:0] h;
      case (r.size)
         size_byte: begin
            b = model[r.addr];
            return r.unsigned_ld ? {24'h0, b} : {{24{b[7]}}, b};
         end
         size_half: begin
            // Bit 0 of the address is ignored
            base = {r.addr[9:1], 1'b0};
            h = {model[base + 10'd1], model[base]};
            return r.unsigned_ld ? {16'h0, h} : {{16{h[15]}}, h};
         end
         default: begin
            base = {r.addr[9:2], 2'b00};
            return {model[base + 10'd3], model[base + 10'd2],
                    model[base + 10'd1], model[base]};
         end
      endcase
   endfunction

   // ========================================
   // Monitor
   // ========================================

   always @(posedge clk) begin
      if (rst_n) begin
         if (load_due) begin
            mon_checks++;
            assert (rsp_valid) else begin
               $display("No response one cycle after an accepted load at %0t", $time);
               mon_errors++;
            end
         end
         if (hold_due) begin
            mon_checks++;
            assert (rsp_valid) else begin
               $display("Response dropped while rsp_ready was low at %0t", $time);
               mon_errors++;
            end
            assert (rsp_data == held_data) else begin
               $display("Fail rsp_data held exp %h got %h", held_data, rsp_data);
               mon_errors++;
            end
         end
         if (rsp_valid && rsp_ready) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
               $display("Response at %0t with no load outstanding", $time);
               mon_errors++;
            end else begin
               mon_checks++;
               assert (rsp_data == exp_q[0]) else begin
                  $display("Fail rsp_data exp %h got %h", exp_q[0], rsp_data);
                  mon_errors++;
               end
               void'(exp_q.pop_front());
            end
         end
         hold_due  = rsp_valid && !rsp_ready;
         held_data = rsp_data;
         load_due  = req_valid && req_ready && !req.write;
         if (req_valid && req_ready) begin
            if (req.write) begin
               model_store(req);
            end else begin
               load_count++;
               exp_q.push_back(expected_load(req));
            end
         end
      end
   end

   // Response back-pressure
   always @(negedge clk) begin
      if (ready_mode == 0) begin
         rsp_ready = 1'b1;
      end else if (ready_mode == 1) begin
         if (stretch_left == 0) begin
            rsp_ready    = ~rsp_ready;
            stretch_left = $urandom_range(12, 1);
         end else begin
            stretch_left--;
         end
      end else begin
         rsp_ready = ($urandom_range(3, 0) != 0);
      end
   end

   // ========================================
   // Stimulus helpers
   // ========================================

   function automatic lsu_req_t make_req(input logic [9:0] addr, input size_t size,
                                         input logic write, input logic unsigned_ld,
                                         input logic [31:0] wdata);
      lsu_req_t r;
      r.addr        = addr;
      r.size        = size;
      r.write       = write;
      r.unsigned_ld = unsigned_ld;
      r.wdata       = wdata;
      return r;
   endfunction

   function automatic lsu_req_t random_req(input int write_pct);
      return make_req(10'($urandom), size_t'($urandom_range(2, 0)),
                      $urandom_range(99, 0) < write_pct, 1'($urandom), $urandom);
   endfunction

   // Called on a falling edge and returns on the falling edge after acceptance
   task automatic send_req(input lsu_req_t r);
      req_valid = 1'b1;
      req       = r;
      @(posedge clk);
      while (!req_ready) begin
         @(posedge clk);
      end
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic end_test(input string name, input int errs_before,
                           input int loads_before, input int rsps_before);
      int errs;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      seq_checks++;
      assert (load_count - loads_before == rsp_count - rsps_before) else begin
         $display("Response count differs from accepted loads in %s", name);
         seq_errors++;
      end
      test_count++;
      errs = mon_errors + seq_errors - errs_before;
      if (errs == 0) begin
         $display("test %s: ok, %0d loads answered", name, load_count - loads_before);
      end else begin
         $display("test %s: %0d errors", name, errs);
      end
   endtask

   // ========================================
   // Test sequence
   // ========================================

   initial begin
      logic [31:0] d;
      int          idx;
      int          e0;
      int          l0;
      int          r0;
      clk          = 1'b0;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      rsp_ready    = 1'b1;
      ready_mode   = 0;
      stretch_left = 0;
      load_due     = 1'b0;
      hold_due     = 1'b0;
      held_data    = '0;
      mon_errors   = 0;
      mon_checks   = 0;
      load_count   = 0;
      rsp_count    = 0;
      seq_errors   = 0;
      seq_checks   = 0;
      test_count   = 0;
      void'($urandom(57126));

      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Test 1 checks the idle state out of reset then a word readback
      e0 = 0;
      l0 = 0;
      r0 = 0;
      seq_checks++;
      assert (!rsp_valid && req_ready) else begin
         $display("Fail idle state rsp_valid %h req_ready %h", rsp_valid, req_ready);
         seq_errors++;
      end
      for (int w = 0; w < word_count; w++) begin
         send_req(make_req(10'(w * 4), size_word, 1'b1, 1'b0, $urandom));
      end
      idx = $urandom_range(255, 0);
      d   = $urandom;
      send_req(make_req(10'(idx * 4), size_word, 1'b1, 1'b0, d));
      send_req(make_req(10'(idx * 4), size_word, 1'b0, 1'b0, 32'h0));
      end_test("reset_and_readback", e0, l0, r0);

      // Test 2 merges byte stores into their lanes
      e0 = mon_errors + seq_errors;
      l0 = load_count;
      r0 = rsp_count;
      for (int k = 0; k < 4; k++) begin
         idx = $urandom_range(255, 0);
         send_req(make_req(10'(idx * 4), size_word, 1'b1, 1'b0, $urandom));
         send_req(make_req(10'(idx * 4 + k), size_byte, 1'b1, 1'b0, $urandom));
         send_req(make_req(10'(idx * 4), size_word, 1'b0, 1'b0, 32'h0));
      end
      idx = $urandom_range(255, 0);
      for (int k = 0; k < 4; k++) begin
         send_req(make_req(10'(idx * 4 + k), size_byte, 1'b1, 1'b0, $urandom));
      end
      send_req(make_req(10'(idx * 4), size_word, 1'b0, 1'b0, 32'h0));
      end_test("byte_merge", e0, l0, r0);

      // Test 3 covers signed and unsigned sub-word loads at every offset
      e0 = mon_errors + seq_errors;
      l0 = load_count;
      r0 = rsp_count;
      for (int i = 0; i < t3_words; i++) begin
         idx = $urandom_range(255, 0);
         d   = $urandom;
         // Alternate all sign bits set and all clear
         d   = i[0] ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
         send_req(make_req(10'(idx * 4), size_word, 1'b1, 1'b0, d));
         for (int off = 0; off < 4; off++) begin
            for (int u = 0; u < 2; u++) begin
               send_req(make_req(10'(idx * 4 + off), size_byte, 1'b0, 1'(u), 32'h0));
               send_req(make_req(10'(idx * 4 + off), size_half, 1'b0, 1'(u), 32'h0));
            end
         end
      end
      end_test("extend_loads", e0, l0, r0);

      // Test 4 runs under long back-pressure stretches
      e0 = mon_errors + seq_errors;
      l0 = load_count;
      r0 = rsp_count;
      ready_mode = 1;
      for (int i = 0; i < t4_reqs; i++) begin
         send_req(random_req(25));
      end
      end_test("back_pressure", e0, l0, r0);

      // Test 5 mixes random requests with random rsp_ready and idle gaps
      e0 = mon_errors + seq_errors;
      l0 = load_count;
      r0 = rsp_count;
      ready_mode = 2;
      for (int i = 0; i < t5_reqs; i++) begin
         send_req(random_req(50));
         if ($urandom_range(3, 0) == 0) begin
            @(negedge clk);
         end
      end
      end_test("random_mix", e0, l0, r0);

      $display("tests %0d, checks %0d, errors %0d", test_count,
               mon_checks + seq_checks, mon_errors + seq_errors);
      if (mon_errors + seq_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Run limit scaled by the request count
   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Run timed out after %0d cycles", watchdog_cycles);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: byte_lane_mem.f
hw/lane_mem_pkg.sv
hw/store_aligner.sv
hw/byte_bank.sv
hw/load_extractor.sv
hw/byte_lane_mem.sv
bench/byte_lane_mem_checker.sv
bench/tb_byte_lane_mem.sv

// File: Makefile
SIM       = verilator
SIMFLAGS  = --binary --timing --assert -j 0
TOP       = tb_byte_lane_mem
FILELIST  = byte_lane_mem.f
BUILD_DIR = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
